// File: hdl/am_lock_pkg.sv
package am_lock_pkg;

	localparam int N_ALIGNERS_DEFAULT     = 20;
	localparam int N_BLOCKS_DEFAULT       = 16384;
	localparam int MAX_INVALID_AM_DEFAULT = 8;

	localparam logic [1:0] SH_CTRL = 2'b10; // Control block sync header

	// 64-bit payload seen raw or as marker bytes (M0 first on the wire)
	typedef union packed {
		logic [63:0] raw;
		struct packed {
			logic [7:0] m0;
			logic [7:0] m1;
			logic [7:0] m2;
			logic [7:0] bip3;
			logic [7:0] m4;
			logic [7:0] m5;
			logic [7:0] m6;
			logic [7:0] bip7;
		} fields;
	} am_word_t;

	typedef struct packed {
		logic [1:0] sh;
		am_word_t   payload;
	} pcs_block_t;

	typedef logic [4:0] lane_num_t;

	typedef struct packed {
		pcs_block_t block;
		logic       marker; // Block sits at a marker position
		lane_num_t  lane;
	} out_block_t;

	// {M0, M1, M2} per PCS lane with M4..M6 as the inverse
	localparam logic [23:0] lane_marker_table [0:19] = '{
		24'hC16821, // 0
		24'h9D718E,
		24'h594BE8,
		24'h4D957B,
		24'hF50709,
		24'hDD14C2, // 5
		24'h9A4A26,
		24'h7B4566,
		24'hA02476,
		24'h68C9FB,
		24'hFD6C99, // 10
		24'hB99155,
		24'h5CB9B2,
		24'h1AF8BD,
		24'h83C7CA,
		24'h3536CD, // 15
		24'hC4314C,
		24'hADD6B7,
		24'h5F662A,
		24'hC0F0E5
	};

endpackage

// File: hdl/am_comparator.sv
module am_comparator
#(
	parameter int N_ALIGNERS = am_lock_pkg::N_ALIGNERS_DEFAULT
)
(
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_valid,
	input  am_lock_pkg::pcs_block_t i_block,
	input  logic [N_ALIGNERS-1:0]   i_match_mask,

	output logic                    o_valid,
	output am_lock_pkg::pcs_block_t o_block,
	output logic [N_ALIGNERS-1:0]   o_match_vector,
	output logic                    o_am_valid
);

	import am_lock_pkg::*;

	am_word_t              word;
	logic                  is_ctrl;
	logic                  inv_ok;
	logic [23:0]           m_bytes;
	logic [N_ALIGNERS-1:0] match;

	assign word    = i_block.payload;
	assign is_ctrl = (i_block.sh == SH_CTRL);
	assign m_bytes = {word.fields.m0, word.fields.m1, word.fields.m2};

	// Second half of the marker mirrors the first
	assign inv_ok = (word.fields.m4 == ~word.fields.m0) &&
	                (word.fields.m5 == ~word.fields.m1) &&
	                (word.fields.m6 == ~word.fields.m2);

	// All lanes in parallel
	always_comb
	begin
		for (int i = 0; i < N_ALIGNERS; i++)
		begin
			match[i] = is_ctrl && inv_ok && i_match_mask[i] &&
			           (m_bytes == lane_marker_table[i]);
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_valid <= 1'b0;
		end
		else
		begin
			o_valid <= i_valid;
		end
	end

	// Stage 1 payload
	always_ff @(posedge i_clock)
	begin
		if (i_valid)
		begin
			o_block        <= i_block;
			o_match_vector <= match;
		end
	end

	assign o_am_valid = |o_match_vector; // Any lane hit

endmodule

// File: hdl/am_block_timer.sv
module am_block_timer
#(
	parameter int N_BLOCKS = am_lock_pkg::N_BLOCKS_DEFAULT
)
(
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_step,
	input  logic i_reset_count,

	output logic o_timer_done
);

	localparam int NB_COUNT = $clog2(N_BLOCKS + 1);

	logic [NB_COUNT-1:0] count; // Steps since the requesting step

	// Request is seen on the step after the one that raised it,
	// so a restart loads one
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			count <= NB_COUNT'(N_BLOCKS); // Idle with no marker expected
		end
		else if (i_step)
		begin
			if (i_reset_count)
			begin
				count <= NB_COUNT'(1);
			end
			else if (count != NB_COUNT'(N_BLOCKS))
			begin
				count <= count + 1'b1; // Saturates while idle
			end
		end
	end

	// Expected marker position
	assign o_timer_done = !i_reset_count && (count == NB_COUNT'(N_BLOCKS - 1));

endmodule

// File: hdl/am_lock_fsm.sv
module am_lock_fsm
#(
	parameter int N_ALIGNERS     = am_lock_pkg::N_ALIGNERS_DEFAULT,
	parameter int MAX_INVALID_AM = am_lock_pkg::MAX_INVALID_AM_DEFAULT
)
(
	input  logic                                 i_clock,
	input  logic                                 i_reset,
	input  logic                                 i_step,
	input  logic                                 i_timer_done,
	input  logic                                 i_am_valid,
	input  logic [$clog2(MAX_INVALID_AM+1)-1:0] i_am_invalid_limit,
	input  logic [N_ALIGNERS-1:0]                i_match_vector,

	output logic [N_ALIGNERS-1:0]                o_match_mask,
	output logic                                 o_ignore_sh,
	output logic                                 o_reset_count,
	output logic                                 o_am_lock,
	output logic                                 o_resync,
	output logic                                 o_start_of_lane,
	output logic                                 o_restore_am
);

	localparam int NB_INVALID_CNT = $clog2(MAX_INVALID_AM + 1);

	localparam logic [3:0] INIT     = 4'b1000;
	localparam logic [3:0] WAIT_1ST = 4'b0100;
	localparam logic [3:0] WAIT_2ND = 4'b0010;
	localparam logic [3:0] LOCKED   = 4'b0001;

	logic [3:0]                state;
	logic [3:0]                state_next;
	logic [NB_INVALID_CNT-1:0] invalid_cnt;
	logic [NB_INVALID_CNT-1:0] invalid_cnt_next;
	logic [N_ALIGNERS-1:0]     mask_next;
	logic                      ignore_sh_next;
	logic                      reset_count_next;
	logic                      am_lock_next;
	logic                      resync_next;
	logic                      sol_next;
	logic                      restore_am_next;

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state           <= INIT;
			invalid_cnt     <= '0;
			o_match_mask    <= '1;
			o_ignore_sh     <= 1'b0;
			o_reset_count   <= 1'b0;
			o_am_lock       <= 1'b0;
			o_resync        <= 1'b0;
			o_start_of_lane <= 1'b0;
			o_restore_am    <= 1'b0;
		end
		else if (i_step)
		begin
			state           <= state_next;
			invalid_cnt     <= invalid_cnt_next;
			o_match_mask    <= mask_next;
			o_ignore_sh     <= ignore_sh_next;
			o_reset_count   <= reset_count_next; // Held until the timer sees it
			o_am_lock       <= am_lock_next;
			o_resync        <= resync_next;
			o_start_of_lane <= sol_next;
			o_restore_am    <= restore_am_next;
		end
		else
		begin
			// Pulses last one cycle
			o_resync        <= 1'b0;
			o_start_of_lane <= 1'b0;
			o_restore_am    <= 1'b0;
		end
	end

	always_comb
	begin
		state_next       = state;
		invalid_cnt_next = invalid_cnt;
		mask_next        = o_match_mask;
		ignore_sh_next   = o_ignore_sh;
		am_lock_next     = o_am_lock;
		reset_count_next = 1'b0;
		resync_next      = 1'b0;
		sol_next         = 1'b0;
		restore_am_next  = 1'b0;

		case (state)
			INIT:
			begin
				mask_next        = '1;
				ignore_sh_next   = 1'b0;
				am_lock_next     = 1'b0;
				invalid_cnt_next = '0;
				state_next       = WAIT_1ST;
			end
			WAIT_1ST:
			begin
				if (i_am_valid)
				begin
					mask_next        = i_match_vector; // Narrow to the lane found
					ignore_sh_next   = 1'b1;
					reset_count_next = 1'b1;
					restore_am_next  = 1'b1;
					state_next       = WAIT_2ND;
				end
			end
			WAIT_2ND:
			begin
				if (i_timer_done)
				begin
					restore_am_next = 1'b1;
					if (i_am_valid)
					begin
						am_lock_next     = 1'b1;
						reset_count_next = 1'b1;
						resync_next      = 1'b1;
						sol_next         = 1'b1;
						invalid_cnt_next = '0;
						state_next       = LOCKED;
					end
					else
					begin
						mask_next      = '1; // Search all lanes again
						ignore_sh_next = 1'b0;
						state_next     = WAIT_1ST;
					end
				end
			end
			LOCKED:
			begin
				if (i_timer_done)
				begin
					reset_count_next = 1'b1;
					sol_next         = 1'b1;
					restore_am_next  = 1'b1;
					if (i_am_valid)
					begin
						invalid_cnt_next = '0;
					end
					else if (invalid_cnt >= i_am_invalid_limit)
					begin
						mask_next        = '1;
						ignore_sh_next   = 1'b0;
						am_lock_next     = 1'b0;
						invalid_cnt_next = '0;
						state_next       = WAIT_1ST;
					end
					else
					begin
						invalid_cnt_next = invalid_cnt + 1'b1;
					end
				end
			end
			default:
			begin
				state_next = INIT;
			end
		endcase
	end

endmodule

// File: hdl/am_lane_tagger.sv
module am_lane_tagger
#(
	parameter int N_ALIGNERS = am_lock_pkg::N_ALIGNERS_DEFAULT
)
(
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_step,
	input  am_lock_pkg::pcs_block_t i_block,
	input  logic                    i_restore_am,
	input  logic [N_ALIGNERS-1:0]   i_match_mask,

	output logic                    o_valid,
	output am_lock_pkg::out_block_t o_out
);

	import am_lock_pkg::*;

	pcs_block_t block_q;
	lane_num_t  lane;

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_valid <= 1'b0;
		end
		else
		begin
			o_valid <= i_step;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_step)
		begin
			block_q <= i_block;
		end
	end

	// Lowest set bit wins
	always_comb
	begin
		lane = '0;
		for (int i = N_ALIGNERS - 1; i >= 0; i--)
		begin
			if (i_match_mask[i])
			begin
				lane = lane_num_t'(i);
			end
		end
	end

	// Flag and mask registers load on the same step edge as block_q
	always_comb
	begin
		o_out.block  = block_q;
		o_out.marker = i_restore_am;
		o_out.lane   = lane;
	end

endmodule

// File: hdl/am_lock_lane.sv
module am_lock_lane
#(
	parameter int N_ALIGNERS     = am_lock_pkg::N_ALIGNERS_DEFAULT,
	parameter int N_BLOCKS       = am_lock_pkg::N_BLOCKS_DEFAULT,
	parameter int MAX_INVALID_AM = am_lock_pkg::MAX_INVALID_AM_DEFAULT
)
(
	input  logic                                 i_clock,
	input  logic                                 i_reset,
	input  logic                                 i_enable,
	input  logic                                 i_valid,
	input  am_lock_pkg::pcs_block_t              i_block,
	input  logic [$clog2(MAX_INVALID_AM+1)-1:0] i_am_invalid_limit,

	output logic                                 o_valid,
	output am_lock_pkg::out_block_t              o_out,
	output logic                                 o_am_lock,
	output logic                                 o_resync,
	output logic                                 o_start_of_lane,
	output logic                                 o_ignore_sh
);

	import am_lock_pkg::*;

	logic                  s1_valid;
	pcs_block_t            s1_block;
	logic [N_ALIGNERS-1:0] match_vector;
	logic [N_ALIGNERS-1:0] match_mask;
	logic                  am_valid;
	logic                  step;
	logic                  timer_done;
	logic                  reset_count;
	logic                  restore_am;

	assign step = s1_valid & i_enable; // Stage 1 block gets processed

	am_comparator #(
		.N_ALIGNERS     (N_ALIGNERS)
	) u_comparator (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_valid        (i_valid),
		.i_block        (i_block),
		.i_match_mask   (match_mask),
		.o_valid        (s1_valid),
		.o_block        (s1_block),
		.o_match_vector (match_vector),
		.o_am_valid     (am_valid)
	);

	am_block_timer #(
		.N_BLOCKS      (N_BLOCKS)
	) u_timer (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_step        (step),
		.i_reset_count (reset_count),
		.o_timer_done  (timer_done)
	);

	am_lock_fsm #(
		.N_ALIGNERS         (N_ALIGNERS),
		.MAX_INVALID_AM     (MAX_INVALID_AM)
	) u_fsm (
		.i_clock            (i_clock),
		.i_reset            (i_reset),
		.i_step             (step),
		.i_timer_done       (timer_done),
		.i_am_valid         (am_valid),
		.i_am_invalid_limit (i_am_invalid_limit),
		.i_match_vector     (match_vector),
		.o_match_mask       (match_mask),
		.o_ignore_sh        (o_ignore_sh),
		.o_reset_count      (reset_count),
		.o_am_lock          (o_am_lock),
		.o_resync           (o_resync),
		.o_start_of_lane    (o_start_of_lane),
		.o_restore_am       (restore_am)
	);

	am_lane_tagger #(
		.N_ALIGNERS   (N_ALIGNERS)
	) u_tagger (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_step       (step),
		.i_block      (s1_block),
		.i_restore_am (restore_am),
		.i_match_mask (match_mask),
		.o_valid      (o_valid),
		.o_out        (o_out)
	);

endmodule

// File: tests/am_lock_lane_tb.sv
module am_lock_lane_tb;

	import am_lock_pkg::*;

	localparam int N_BLOCKS     = 16;
	localparam int RESET_CYCLES = 16;
	localparam int STIM_BLOCKS  = 359; // Blocks sent by the sequence below
	localparam int MAX_CYCLES   = RESET_CYCLES + (STIM_BLOCKS * 3) / 2;

	localparam logic [23:0] LANE7_AM = 24'h7B4566; // M0 M1 M2 of PCS lane 7

	localparam int S_INIT   = 0;
	localparam int S_WAIT1  = 1;
	localparam int S_WAIT2  = 2;
	localparam int S_LOCKED = 3;

	logic       i_clock;
	logic       i_reset;
	logic       i_enable;
	logic       i_valid;
	pcs_block_t i_block;
	logic [3:0] i_am_invalid_limit;
	logic       o_valid;
	out_block_t o_out;
	logic       o_am_lock;
	logic       o_resync;
	logic       o_start_of_lane;
	logic       o_ignore_sh;

	logic marker_tag; // Block on i_block is a lane 7 marker
	int   errors = 0;
	int   cycles = 0;

	// Reference model
	logic       m_s1_valid;
	pcs_block_t m_s1_block;
	logic       m_s1_am;
	int         m_state;
	int         m_cnt;
	int         m_pos; // Steps since the last timer restart
	logic       m_mask_all;
	logic       m_lock;
	logic       m_ignore;
	logic       exp_valid;
	logic       exp_lock;
	logic       exp_resync;
	logic       exp_sol;
	logic       exp_ignore;
	out_block_t exp_out;

	am_lock_lane #(
		.N_BLOCKS           (N_BLOCKS)
	) i_dut (
		.i_clock            (i_clock),
		.i_reset            (i_reset),
		.i_enable           (i_enable),
		.i_valid            (i_valid),
		.i_block            (i_block),
		.i_am_invalid_limit (i_am_invalid_limit),
		.o_valid            (o_valid),
		.o_out              (o_out),
		.o_am_lock          (o_am_lock),
		.o_resync           (o_resync),
		.o_start_of_lane    (o_start_of_lane),
		.o_ignore_sh        (o_ignore_sh)
	);

	always #50 i_clock = ~i_clock;

	always @(posedge i_clock)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Run stopped at cycle %0d before the stimulus finished", cycles);
			$display("Errors: %0d", errors);
			$display("Test failed");
			$finish;
		end
	end

	always @(posedge i_clock)
	begin : ref_model
		int   pos;
		logic done;
		logic req;
		logic flag;
		logic resync;
		logic sol;
		if (i_reset)
		begin
			m_s1_valid = 1'b0;
			m_state    = S_INIT;
			m_cnt      = 0;
			m_pos      = 1 << 20; // Nothing expected yet
			m_mask_all = 1'b1;
			m_lock     = 1'b0;
			m_ignore   = 1'b0;
			exp_valid  <= 1'b0;
			exp_lock   <= 1'b0;
			exp_resync <= 1'b0;
			exp_sol    <= 1'b0;
			exp_ignore <= 1'b0;
		end
		else
		begin
			exp_valid      <= m_s1_valid && i_enable;
			exp_resync     <= 1'b0;
			exp_sol        <= 1'b0;
			exp_out.marker <= 1'b0;
			if (m_s1_valid && i_enable)
			begin
				pos    = m_pos + 1;
				done   = (pos == N_BLOCKS);
				req    = 1'b0;
				flag   = 1'b0;
				resync = 1'b0;
				sol    = 1'b0;
				case (m_state)
					S_INIT:
					begin
						m_mask_all = 1'b1;
						m_ignore   = 1'b0;
						m_lock     = 1'b0;
						m_cnt      = 0;
						m_state    = S_WAIT1;
					end
					S_WAIT1:
					begin
						if (m_s1_am)
						begin
							m_mask_all = 1'b0;
							m_ignore   = 1'b1;
							req        = 1'b1;
							flag       = 1'b1;
							m_state    = S_WAIT2;
						end
					end
					S_WAIT2:
					begin
						if (done && m_s1_am)
						begin
							m_lock  = 1'b1;
							req     = 1'b1;
							resync  = 1'b1;
							sol     = 1'b1;
							m_cnt   = 0;
							m_state = S_LOCKED;
						end
						else if (done)
						begin
							m_mask_all = 1'b1;
							m_ignore   = 1'b0;
							m_state    = S_WAIT1;
						end
						flag = done;
					end
					default:
					begin
						if (done)
						begin
							req  = 1'b1;
							sol  = 1'b1;
							flag = 1'b1;
							if (m_s1_am)
							begin
								m_cnt = 0;
							end
							else if (m_cnt >= i_am_invalid_limit)
							begin
								m_mask_all = 1'b1;
								m_ignore   = 1'b0;
								m_lock     = 1'b0;
								m_cnt      = 0;
								m_state    = S_WAIT1;
							end
							else
							begin
								m_cnt = m_cnt + 1;
							end
						end
					end
				endcase
				m_pos          = req ? 0 : pos;
				exp_lock       <= m_lock;
				exp_ignore     <= m_ignore;
				exp_resync     <= resync;
				exp_sol        <= sol;
				exp_out.block  <= m_s1_block;
				exp_out.marker <= flag;
				exp_out.lane   <= m_mask_all ? 5'd0 : 5'd7; // Lowest lane left in the mask
			end
			// Lane 7 markers pass the mask in every state
			m_s1_valid = i_valid;
			if (i_valid)
			begin
				m_s1_block = i_block;
				m_s1_am    = marker_tag;
			end
		end
	end

	task automatic report_mismatch(input string name, input logic [71:0] expected,
		input logic [71:0] actual);
		errors++;
		$display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
	endtask

	assert property (@(posedge i_clock) disable iff (i_reset) o_valid == exp_valid)
		else report_mismatch("o_valid", $sampled(exp_valid), $sampled(o_valid));
	assert property (@(posedge i_clock) disable iff (i_reset) o_am_lock == exp_lock)
		else report_mismatch("o_am_lock", $sampled(exp_lock), $sampled(o_am_lock));
	assert property (@(posedge i_clock) disable iff (i_reset) o_resync == exp_resync)
		else report_mismatch("o_resync", $sampled(exp_resync), $sampled(o_resync));
	assert property (@(posedge i_clock) disable iff (i_reset) o_start_of_lane == exp_sol)
		else report_mismatch("o_start_of_lane", $sampled(exp_sol), $sampled(o_start_of_lane));
	assert property (@(posedge i_clock) disable iff (i_reset) o_ignore_sh == exp_ignore)
		else report_mismatch("o_ignore_sh", $sampled(exp_ignore), $sampled(o_ignore_sh));
	assert property (@(posedge i_clock) disable iff (i_reset) o_valid |-> o_out == exp_out)
		else report_mismatch("o_out", $sampled(exp_out), $sampled(o_out));

	task automatic send_one(input logic marker, input logic en);
		@(posedge i_clock);
		#10;
		i_enable   = en;
		i_valid    = 1'b1;
		marker_tag = marker;
		if (marker)
		begin
			i_block.sh          = 2'b10;
			i_block.payload.raw = {LANE7_AM, 8'($urandom), ~LANE7_AM, 8'($urandom)};
		end
		else
		begin
			i_block.sh          = 2'b01; // Data header
			i_block.payload.raw = {$urandom, $urandom};
		end
	endtask

	task automatic send_filler(input int count, input logic en);
		repeat (count) send_one(1'b0, en);
	endtask

	// One marker period with the marker optionally left out
	task automatic send_period(input int gap, input logic with_marker);
		send_one(with_marker, 1'b1);
		send_filler(gap - 1, 1'b1);
	endtask

	task automatic expect_lock(input logic wanted, input string what);
		assert (o_am_lock === wanted)
		else
		begin
			errors++;
			$display("Error at %0t: o_am_lock expected %b, got %b after %s", $time, wanted,
				o_am_lock, what);
		end
	endtask

	initial
	begin
		void'($urandom(32'hb2d8d6df));
		i_clock            = 1'b0;
		i_reset            = 1'b1;
		i_enable           = 1'b1;
		i_valid            = 1'b0;
		i_block            = '0;
		i_am_invalid_limit = 4'd2;
		marker_tag         = 1'b0;
		repeat (RESET_CYCLES) @(posedge i_clock);
		#10;
		i_reset = 1'b0;

		send_filler(3, 1'b1);
		send_period(N_BLOCKS, 1'b1);
		expect_lock(1'b0, "first marker");
		send_period(N_BLOCKS, 1'b1);
		expect_lock(1'b1, "second marker");
		send_period(N_BLOCKS, 1'b1);

		repeat (2) send_period(N_BLOCKS, 1'b0); // Limit 2
		expect_lock(1'b1, "two misses at limit 2");
		send_period(N_BLOCKS, 1'b0);
		expect_lock(1'b0, "three misses at limit 2");

		send_period(10, 1'b1);
		send_period(6, 1'b1); // Wrong spacing
		send_period(N_BLOCKS, 1'b0);
		expect_lock(1'b0, "marker at wrong spacing");
		repeat (2) send_period(N_BLOCKS, 1'b1);
		expect_lock(1'b1, "restarted search");

		i_am_invalid_limit = 4'd1;
		send_period(N_BLOCKS, 1'b1);
		send_period(N_BLOCKS, 1'b0);
		expect_lock(1'b1, "one miss at limit 1");
		send_period(N_BLOCKS, 1'b0);
		expect_lock(1'b0, "two misses at limit 1");

		repeat (2) send_period(N_BLOCKS, 1'b1);
		repeat (2)
		begin
			send_period(N_BLOCKS, 1'b0);
			send_period(N_BLOCKS, 1'b1);
		end
		expect_lock(1'b1, "misses split by valid markers");

		send_filler(20, 1'b0);
		expect_lock(1'b1, "lane disabled");
		repeat (2) send_period(N_BLOCKS, 1'b1);
		expect_lock(1'b1, "lane enabled again");

		@(posedge i_clock);
		#10;
		i_valid = 1'b0;
		repeat (4) @(posedge i_clock);

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: am_lock_lane.f
hdl/am_lock_pkg.sv
hdl/am_comparator.sv
hdl/am_block_timer.sv
hdl/am_lock_fsm.sv
hdl/am_lane_tagger.sv
hdl/am_lock_lane.sv
tests/am_lock_lane_tb.sv

// File: Bender.yml
package:
  name: am_lock_lane

sources:
  - files:
      - hdl/am_lock_pkg.sv
      - hdl/am_comparator.sv
      - hdl/am_block_timer.sv
      - hdl/am_lock_fsm.sv
      - hdl/am_lane_tagger.sv
      - hdl/am_lock_lane.sv
  - target: test
    files:
      - tests/am_lock_lane_tb.sv
